// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f icache.f --top-module icache_top
	verilator --lint-only --timing -f icache.f --top-module tb_icache

obj_dir/tb_icache: icache.f common/*.sv icache/*.sv design/*.sv test/*.sv
	verilator --binary --timing --assert -f icache.f --top-module tb_icache -o tb_icache

sim: obj_dir/tb_icache
	./obj_dir/tb_icache | tee /dev/stderr | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

// ==== common/icache_pkg.sv ====
package icache_pkg;

    // Default geometry
    parameter int ADDR_BITS      = 32;
    parameter int LINE_BYTES     = 16;
    parameter int WORDS_PER_LINE = 4;
    parameter int LINE_BITS      = 128;
    parameter int SET_BITS       = 4;
    parameter int WAYS           = 4;
    parameter int UNCACHED_BIT   = 31;

    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int WAY_BITS    = $clog2(WAYS);
    localparam int TAG_BITS    = ADDR_BITS - SET_BITS - OFFSET_BITS;

    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_CHECK_HIT,
        ST_WAIT_GRANT,
        ST_WAIT_RESP,
        ST_FILL,
        ST_FLUSH_LOOKUP,
        ST_FLUSH_WRITE
    } ctrl_state_e;

    typedef struct packed {
        logic [31:0]          word;
        logic [ADDR_BITS-1:0] addr;
        logic                 load_fault;
    } fetch_resp_t;

    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic                 cached;   // Full line wanted
    } mem_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] line;     // Uncached word in word 0
        logic                 load_fault;
    } mem_resp_t;

    typedef struct packed {
        logic [WAY_BITS-1:0]  way;
        logic [SET_BITS-1:0]  index;
        logic [TAG_BITS-1:0]  tag;
        logic [LINE_BITS-1:0] line;
        logic                 valid;
        logic                 direct;   // Way given, not found by hit
    } tag_wr_t;

    function automatic logic [ADDR_BITS-1:0] line_base(input logic [ADDR_BITS-1:0] addr);
        return {addr[ADDR_BITS-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    endfunction

    function automatic logic [ADDR_BITS-1:0] word_base(input logic [ADDR_BITS-1:0] addr);
        return {addr[ADDR_BITS-1:2], 2'b00};
    endfunction

    function automatic logic is_uncached(input logic [ADDR_BITS-1:0] addr);
        return addr[UNCACHED_BIT];
    endfunction

endpackage

// ==== design/icache_top.sv ====
module icache_top
    import icache_pkg::*;
#(
    parameter int ADDR_BITS = icache_pkg::ADDR_BITS,
    parameter int SET_BITS  = icache_pkg::SET_BITS,
    parameter int WAYS      = icache_pkg::WAYS
) (
    input  logic                 i_clk,
    input  logic                 i_nrst,
    input  logic                 i_req_valid,
    input  logic [ADDR_BITS-1:0] i_req_addr,
    output logic                 o_req_ready,
    output logic                 o_resp_valid,
    output fetch_resp_t          o_resp,
    input  logic                 i_resp_ready,
    output logic                 o_mem_valid,
    output mem_req_t             o_mem_req,
    input  logic                 i_mem_ready,
    input  logic                 i_mem_data_valid,
    input  mem_resp_t            i_mem_resp,
    input  logic                 i_flush_valid,
    input  logic [ADDR_BITS-1:0] i_flush_addr
);

    logic                    tag_re, tag_we, tag_hit, lru_we;
    logic [ADDR_BITS-1:0]    tag_addr;
    tag_wr_t                 tag_wr;
    logic [$clog2(WAYS)-1:0] tag_hit_way, lru_way, lru_victim;
    logic [31:0]             tag_word;
    logic [SET_BITS-1:0]     lru_index;

    icache_ctrl #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS), .WAYS(WAYS)) u_ctrl (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req_valid(i_req_valid), .i_req_addr(i_req_addr), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp), .i_resp_ready(i_resp_ready),
        .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req), .i_mem_ready(i_mem_ready),
        .i_mem_data_valid(i_mem_data_valid), .i_mem_resp(i_mem_resp),
        .i_flush_valid(i_flush_valid), .i_flush_addr(i_flush_addr),
        .o_tag_re(tag_re), .o_tag_addr(tag_addr), .o_tag_we(tag_we), .o_tag_wr(tag_wr),
        .i_tag_hit(tag_hit), .i_tag_hit_way(tag_hit_way), .i_tag_word(tag_word),
        .o_lru_we(lru_we), .o_lru_index(lru_index), .o_lru_way(lru_way),
        .i_lru_victim(lru_victim)
    );

    icache_tag_mem #(.ADDR_BITS(ADDR_BITS), .SET_BITS(SET_BITS), .WAYS(WAYS)) u_tag_mem (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_re(tag_re), .i_addr(tag_addr), .i_we(tag_we), .i_wr(tag_wr),
        .o_hit(tag_hit), .o_hit_way(tag_hit_way), .o_word(tag_word)
    );

    icache_lru #(.SET_BITS(SET_BITS), .WAYS(WAYS)) u_lru (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_we(lru_we), .i_index(lru_index), .i_way(lru_way), .o_victim(lru_victim)
    );

endmodule

// ==== icache.f ====
common/icache_pkg.sv
icache/icache_lru.sv
icache/icache_tag_mem.sv
icache/icache_ctrl.sv
design/icache_top.sv
test/icache_checker.sv
test/tb_icache.sv

// ==== icache/icache_ctrl.sv ====
module icache_ctrl
    import icache_pkg::*;
#(
    parameter int ADDR_BITS,
    parameter int SET_BITS,
    parameter int WAYS
) (
    input  logic                     i_clk,
    input  logic                     i_nrst,
    // Core side
    input  logic                     i_req_valid,
    input  logic [ADDR_BITS-1:0]     i_req_addr,
    output logic                     o_req_ready,
    output logic                     o_resp_valid,
    output fetch_resp_t              o_resp,
    input  logic                     i_resp_ready,
    // Memory side
    output logic                     o_mem_valid,
    output mem_req_t                 o_mem_req,
    input  logic                     i_mem_ready,
    input  logic                     i_mem_data_valid,
    input  mem_resp_t                i_mem_resp,
    // Flush
    input  logic                     i_flush_valid,
    input  logic [ADDR_BITS-1:0]     i_flush_addr,
    // Tag memory
    output logic                     o_tag_re,
    output logic [ADDR_BITS-1:0]     o_tag_addr,
    output logic                     o_tag_we,
    output tag_wr_t                  o_tag_wr,
    input  logic                     i_tag_hit,
    input  logic [$clog2(WAYS)-1:0]  i_tag_hit_way,
    input  logic [31:0]              i_tag_word,
    // LRU
    output logic                     o_lru_we,
    output logic [SET_BITS-1:0]      o_lru_index,
    output logic [$clog2(WAYS)-1:0]  o_lru_way,
    input  logic [$clog2(WAYS)-1:0]  i_lru_victim
);

    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = ADDR_BITS - SET_BITS - OFFSET_BITS;

    ctrl_state_e state_q, state_d;
    logic        mem_valid_q, mem_valid_d;
    logic        bypass_q, bypass_d;        // Respond from line_q instead of the tag memory
    logic        fill_wr_q, fill_wr_d;
    logic        flush_pend_q, flush_pend_d;
    logic        flush_all_q;
    logic [SET_BITS+WAY_W-1:0] walk_cnt_q, walk_cnt_d;

    logic [ADDR_BITS-1:0] req_addr_q;
    logic [ADDR_BITS-1:0] flush_addr_q;
    mem_req_t             mem_req_q;
    logic [LINE_BITS-1:0] line_q;
    logic                 fault_q;

    logic take_req;
    logic issue_mem;
    logic take_mem;

    always_comb begin
        state_d      = state_q;
        mem_valid_d  = mem_valid_q;
        bypass_d     = bypass_q;
        fill_wr_d    = fill_wr_q;
        flush_pend_d = flush_pend_q;
        walk_cnt_d   = walk_cnt_q;
        take_req     = 1'b0;
        issue_mem    = 1'b0;
        take_mem     = 1'b0;
        o_req_ready  = 1'b0;
        o_resp_valid = 1'b0;
        o_tag_re     = 1'b0;
        o_tag_we     = 1'b0;
        o_lru_we     = 1'b0;

        // Walk entry invalidate by default
        o_tag_wr.way    = walk_cnt_q[WAY_W-1:0];
        o_tag_wr.index  = walk_cnt_q[WAY_W +: SET_BITS];
        o_tag_wr.tag    = '0;
        o_tag_wr.line   = '0;
        o_tag_wr.valid  = 1'b0;
        o_tag_wr.direct = 1'b1;

        case (state_q)
            ST_RESET: begin
                o_tag_we   = 1'b1;
                walk_cnt_d = walk_cnt_q + 1'b1;
                if (&walk_cnt_q) begin
                    state_d = ST_IDLE;
                end
            end
            ST_IDLE: begin
                if (flush_pend_q) begin
                    flush_pend_d = 1'b0;
                    walk_cnt_d   = '0;
                    state_d      = flush_all_q ? ST_FLUSH_WRITE : ST_FLUSH_LOOKUP;
                end else begin
                    o_req_ready = 1'b1;
                    if (i_req_valid) begin
                        o_tag_re = 1'b1;
                        take_req = 1'b1;
                        state_d  = ST_CHECK_HIT;
                    end
                end
            end
            ST_CHECK_HIT: begin
                if (bypass_q || i_tag_hit) begin
                    o_resp_valid = 1'b1;
                    if (i_resp_ready) begin
                        o_lru_we = !bypass_q;
                        bypass_d = 1'b0;
                        state_d  = ST_IDLE;
                    end
                end else begin
                    issue_mem   = 1'b1;
                    mem_valid_d = 1'b1;
                    state_d     = ST_WAIT_GRANT;
                end
            end
            ST_WAIT_GRANT: begin
                if (i_mem_ready) begin
                    mem_valid_d = 1'b0;
                    state_d     = ST_WAIT_RESP;
                end
            end
            ST_WAIT_RESP: begin
                if (i_mem_data_valid) begin
                    take_mem = 1'b1;
                    if (mem_req_q.cached && !i_mem_resp.load_fault) begin
                        state_d = ST_FILL;
                    end else begin
                        bypass_d = 1'b1;
                        state_d  = ST_CHECK_HIT;
                    end
                end
            end
            ST_FILL: begin
                if (!fill_wr_q) begin
                    o_tag_we        = 1'b1;   // Line into victim way
                    o_tag_wr.way    = i_lru_victim;
                    o_tag_wr.index  = req_addr_q[OFFSET_BITS +: SET_BITS];
                    o_tag_wr.tag    = req_addr_q[ADDR_BITS-1 -: TAG_W];
                    o_tag_wr.line   = line_q;
                    o_tag_wr.valid  = 1'b1;
                    fill_wr_d       = 1'b1;
                end else begin
                    o_tag_re  = 1'b1;         // Re-read so the hit path returns the word
                    fill_wr_d = 1'b0;
                    state_d   = ST_CHECK_HIT;
                end
            end
            ST_FLUSH_LOOKUP: begin
                o_tag_re = 1'b1;
                state_d  = ST_FLUSH_WRITE;
            end
            ST_FLUSH_WRITE: begin
                o_tag_we = 1'b1;
                if (flush_all_q) begin
                    walk_cnt_d = walk_cnt_q + 1'b1;
                    if (&walk_cnt_q) begin
                        state_d = ST_IDLE;
                    end
                end else begin
                    // Only the way found by the lookup is cleared
                    o_tag_wr.index  = flush_addr_q[OFFSET_BITS +: SET_BITS];
                    o_tag_wr.tag    = flush_addr_q[ADDR_BITS-1 -: TAG_W];
                    o_tag_wr.direct = 1'b0;
                    state_d         = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_RESET;
            end
        endcase

        if (i_flush_valid) begin
            flush_pend_d = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q      <= ST_RESET;
            mem_valid_q  <= 1'b0;
            bypass_q     <= 1'b0;
            fill_wr_q    <= 1'b0;
            flush_pend_q <= 1'b0;
            flush_all_q  <= 1'b0;
            walk_cnt_q   <= '0;
        end else begin
            state_q      <= state_d;
            mem_valid_q  <= mem_valid_d;
            bypass_q     <= bypass_d;
            fill_wr_q    <= fill_wr_d;
            flush_pend_q <= flush_pend_d;
            walk_cnt_q   <= walk_cnt_d;
            if (i_flush_valid) begin
                flush_all_q <= i_flush_addr[0];
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take_req) begin
            req_addr_q <= i_req_addr;
        end
        if (issue_mem) begin
            mem_req_q.cached <= !is_uncached(req_addr_q);
            mem_req_q.addr   <= is_uncached(req_addr_q) ? word_base(req_addr_q)
                                                        : line_base(req_addr_q);
        end
        if (take_mem) begin
            line_q  <= i_mem_resp.load_fault ? '1 : i_mem_resp.line;  // All ones on fault
            fault_q <= i_mem_resp.load_fault;
        end
        if (i_flush_valid) begin
            flush_addr_q <= i_flush_addr;
        end
    end

    assign o_tag_addr = (state_q == ST_IDLE) ? i_req_addr :
                        (state_q == ST_FLUSH_LOOKUP) ? flush_addr_q : req_addr_q;

    assign o_mem_valid = mem_valid_q;
    assign o_mem_req   = mem_req_q;

    assign o_resp.word       = bypass_q ? line_q[31:0] : i_tag_word;
    assign o_resp.addr       = req_addr_q;
    assign o_resp.load_fault = bypass_q && fault_q;

    assign o_lru_index = req_addr_q[OFFSET_BITS +: SET_BITS];
    assign o_lru_way   = i_tag_hit_way;

    // Memory request held until granted
    assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_mem_valid && !i_mem_ready |=> o_mem_valid && $stable(o_mem_req));

    // Response held while the core stalls it
    assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp));

endmodule

// ==== icache/icache_lru.sv ====
module icache_lru #(
    parameter int SET_BITS,
    parameter int WAYS
) (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_we,
    input  logic [SET_BITS-1:0]     i_index,
    input  logic [$clog2(WAYS)-1:0] i_way,
    output logic [$clog2(WAYS)-1:0] o_victim
);

    localparam int WAY_W = $clog2(WAYS);

    // Tree bits per set, node 0 is the root
    logic [WAYS-2:0] tree_q [2**SET_BITS];
    logic [WAYS-2:0] tree_next;

    // Follow the bits down to the victim, zero means left
    always_comb begin
        int node;
        node     = 0;
        o_victim = '0;
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            o_victim[WAY_W-1-lvl] = tree_q[i_index][node];
            node = 2 * node + 1 + int'(tree_q[i_index][node]);
        end
    end

    // Point each node on the path away from the used way
    always_comb begin
        int node;
        node      = 0;
        tree_next = tree_q[i_index];
        for (int lvl = 0; lvl < WAY_W; lvl++) begin
            tree_next[node] = ~i_way[WAY_W-1-lvl];
            node = 2 * node + 1 + int'(i_way[WAY_W-1-lvl]);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            tree_q <= '{default: '0};   // Way 0 first
        end else if (i_we) begin
            tree_q[i_index] <= tree_next;
        end
    end

endmodule

// ==== icache/icache_tag_mem.sv ====
module icache_tag_mem
    import icache_pkg::*;
#(
    parameter int ADDR_BITS,
    parameter int SET_BITS,
    parameter int WAYS
) (
    input  logic                    i_clk,
    input  logic                    i_nrst,
    input  logic                    i_re,
    input  logic [ADDR_BITS-1:0]    i_addr,
    input  logic                    i_we,
    input  tag_wr_t                 i_wr,
    output logic                    o_hit,
    output logic [$clog2(WAYS)-1:0] o_hit_way,
    output logic [31:0]             o_word
);

    localparam int SETS   = 2 ** SET_BITS;
    localparam int WAY_W  = $clog2(WAYS);
    localparam int TAG_W  = ADDR_BITS - SET_BITS - OFFSET_BITS;
    localparam int WORD_W = $clog2(WORDS_PER_LINE);

    // Storage per way and set
    logic [TAG_W-1:0]     tag_mem   [WAYS][SETS];
    logic                 valid_mem [WAYS][SETS];
    logic [LINE_BITS-1:0] line_mem  [WAYS][SETS];

    logic [SET_BITS-1:0]  rd_index;
    logic [TAG_W-1:0]     rd_tag;
    logic [WORD_W-1:0]    rd_word;
    logic [WAYS-1:0]      hit_vec;
    logic [WAY_W-1:0]     hit_way;
    logic [LINE_BITS-1:0] hit_line;

    logic                 wr_en;
    logic [WAY_W-1:0]     wr_way;

    assign rd_index = i_addr[OFFSET_BITS +: SET_BITS];
    assign rd_tag   = i_addr[ADDR_BITS-1 -: TAG_W];
    assign rd_word  = i_addr[2 +: WORD_W];

    // All ways of the set compared at once
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = valid_mem[w][rd_index] && (tag_mem[w][rd_index] == rd_tag);
            if (hit_vec[w]) begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign hit_line = line_mem[hit_way][rd_index];

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_hit     <= 1'b0;
            o_hit_way <= '0;
        end else if (i_re) begin
            o_hit     <= |hit_vec;
            o_hit_way <= hit_way;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_re) begin
            o_word <= hit_line[32*rd_word +: 32];   // Addressed word of the line
        end
    end

    // Flush write lands on the way from the previous lookup
    assign wr_en  = i_we && (i_wr.direct || o_hit);
    assign wr_way = i_wr.direct ? i_wr.way : o_hit_way;

    always_ff @(posedge i_clk) begin
        if (wr_en) begin
            tag_mem[wr_way][i_wr.index]   <= i_wr.tag;
            valid_mem[wr_way][i_wr.index] <= i_wr.valid;
            line_mem[wr_way][i_wr.index]  <= i_wr.line;
        end
    end

    // Controller never fills a line that is already resident
    assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_re |-> $onehot0(hit_vec));

endmodule

// ==== test/icache_checker.sv ====
module icache_checker
    import icache_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_nrst,
    input  logic        i_req_valid,
    input  logic        i_req_ready,
    input  logic        i_resp_valid,
    input  fetch_resp_t i_resp,
    input  logic        i_resp_ready,
    input  logic        i_mem_valid,
    input  logic        i_mem_ready,
    input  mem_req_t    i_mem_req,
    input  logic [31:0] i_exp_addr,
    input  logic [31:0] i_exp_word,
    input  logic        i_exp_fault,
    input  logic        i_exp_refill,
    input  int          i_test_num,
    input  logic        i_flush_done,
    input  logic        i_report,
    output int          o_errors
);

    timeunit 1ns;
    timeprecision 100ps;

    int          tests = 0;
    int          refills = 0;
    int          ready_cnt = 0;
    int          lat;
    int          mem_cnt;
    logic        busy = 1'b0;
    logic        seen;
    logic        bad;
    fetch_resp_t held;

    initial o_errors = 0;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
            o_errors++;
            bad = 1'b1;
        end
    endtask

    task automatic report_error(input string what);
        $display("Error at t=%0t: %s", $time, what);
        o_errors++;
        bad = 1'b1;
    endtask

    // Line aligned when cached, word aligned when bit 31 is set
    task automatic check_mem_req();
        logic        exp_cached;
        logic [31:0] exp_req_addr;
        exp_cached   = !i_exp_addr[31];
        exp_req_addr = exp_cached ? {i_exp_addr[31:4], 4'h0} : {i_exp_addr[31:2], 2'b00};
        check_value("o_mem_req.addr", i_mem_req.addr, exp_req_addr);
        check_value("o_mem_req.cached", 32'(i_mem_req.cached), 32'(exp_cached));
    endtask

    task automatic finish_fetch();
        check_value("o_resp.word", i_resp.word, i_exp_word);
        check_value("o_resp.addr", i_resp.addr, i_exp_addr);
        check_value("o_resp.load_fault", 32'(i_resp.load_fault), 32'(i_exp_fault));
        check_value("refill", 32'(mem_cnt != 0), 32'(i_exp_refill));
        refills += mem_cnt;
        tests++;
        $display("test %0d fetch %h %s, %0d memory requests", i_test_num, i_exp_addr,
                 bad ? "FAILED" : "ok", mem_cnt);
    endtask

    always @(posedge i_clk) begin
        if (!i_nrst) begin
            busy      = 1'b0;
            ready_cnt = 0;
        end else begin
            if (i_req_ready && ready_cnt < 64) begin
                report_error("request port ready before the reset walk ended");
            end
            if (ready_cnt < 64) ready_cnt++;
            if (busy) begin
                lat++;
                if (i_mem_valid && i_mem_ready) begin
                    mem_cnt++;
                    check_mem_req();
                end
                if (i_req_valid && i_req_ready) begin
                    report_error("new request accepted while a response was pending");
                end
                if (i_resp_valid) begin
                    if (!seen) begin
                        seen = 1'b1;
                        held = i_resp;
                        if (!i_exp_refill && lat != 1) begin
                            report_error("hit response not one cycle after acceptance");
                        end
                    end else if (i_resp !== held) begin
                        report_error("response changed while the core stalled it");
                    end
                    if (i_resp_ready) begin
                        finish_fetch();
                        busy = 1'b0;
                    end
                end
            end else if (i_req_valid && i_req_ready) begin
                busy    = 1'b1;     // Fetch accepted
                bad     = 1'b0;
                seen    = 1'b0;
                lat     = 0;
                mem_cnt = 0;
            end
            if (i_flush_done) begin
                tests++;
                $display("test %0d flush done", i_test_num);
            end
        end
    end

    always @(posedge i_report) begin
        $display("%0d tests, %0d errors, %0d memory requests", tests, o_errors, refills);
    end

endmodule

// ==== test/icache_tests.txt ====
// op(01 fetch, 02 flush line, 03 flush all)_address_word_fault_refill_stall
// Set 2 holds the pseudo-LRU sequence, bit 31 is uncached, 0x40000xxx faults
01_00000104_5a5a0104_0_1_00
01_0000010c_5a5a010c_0_0_00
01_00000108_5a5a0108_0_0_03
01_00001020_5a5a1020_0_1_00
01_00002024_5a5a2024_0_1_00
01_00003028_5a5a3028_0_1_00
01_0000402c_5a5a402c_0_1_00
01_00001024_5a5a1024_0_0_00
01_00005020_5a5a5020_0_1_00
01_00003020_5a5a3020_0_0_00
01_00004020_5a5a4020_0_0_00
01_00002020_5a5a2020_0_1_00
01_00001028_5a5a1028_0_1_00
01_0000502c_5a5a502c_0_1_00
01_00004024_5a5a4024_0_0_00
01_80000010_da5a0010_0_1_00
01_80000010_da5a0010_0_1_02
01_80000018_da5a0018_0_1_00
01_40000100_ffffffff_1_1_00
01_40000100_ffffffff_1_1_00
02_00000100_00000000_0_0_00
01_00000100_5a5a0100_0_1_00
01_00004028_5a5a4028_0_0_00
03_00000001_00000000_0_0_00
01_00004020_5a5a4020_0_1_00
01_00000104_5a5a0104_0_1_02
01_00000104_5a5a0104_0_0_00

// ==== test/tb_icache.sv ====
module tb_icache
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_TESTS = 64;

    logic                 i_clk;
    logic                 i_nrst;
    logic                 i_req_valid;
    logic [ADDR_BITS-1:0] i_req_addr;
    logic                 o_req_ready;
    logic                 o_resp_valid;
    fetch_resp_t          o_resp;
    logic                 i_resp_ready;
    logic                 o_mem_valid;
    mem_req_t             o_mem_req;
    logic                 i_mem_ready;
    logic                 i_mem_data_valid;
    mem_resp_t            i_mem_resp;
    logic                 i_flush_valid;
    logic [ADDR_BITS-1:0] i_flush_addr;

    // Expected values for the checker
    logic [31:0] exp_addr;
    logic [31:0] exp_word;
    logic        exp_fault;
    logic        exp_refill;
    int          test_num;
    logic        flush_done;
    logic        report;
    int          errors;

    // One line per test holding op, address, word, fault, refill and stall
    logic [87:0] vectors [MAX_TESTS];
    int          num_tests;
    int          cycles;
    int          limit;
    logic [31:0] lcg_state;

    icache_top #(.ADDR_BITS(32), .SET_BITS(4), .WAYS(4)) u_dut (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req_valid(i_req_valid), .i_req_addr(i_req_addr), .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid), .o_resp(o_resp), .i_resp_ready(i_resp_ready),
        .o_mem_valid(o_mem_valid), .o_mem_req(o_mem_req), .i_mem_ready(i_mem_ready),
        .i_mem_data_valid(i_mem_data_valid), .i_mem_resp(i_mem_resp),
        .i_flush_valid(i_flush_valid), .i_flush_addr(i_flush_addr)
    );

    icache_checker u_checker (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_req_valid(i_req_valid), .i_req_ready(o_req_ready),
        .i_resp_valid(o_resp_valid), .i_resp(o_resp), .i_resp_ready(i_resp_ready),
        .i_mem_valid(o_mem_valid), .i_mem_ready(i_mem_ready), .i_mem_req(o_mem_req),
        .i_exp_addr(exp_addr), .i_exp_word(exp_word), .i_exp_fault(exp_fault),
        .i_exp_refill(exp_refill), .i_test_num(test_num), .i_flush_done(flush_done),
        .i_report(report), .o_errors(errors)
    );

    always #20 i_clk = ~i_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {16'h0, lcg_state[31:16]};
    endfunction

    // Each word is its address XOR the pattern and one window faults
    function automatic mem_resp_t make_resp(input mem_req_t req);
        mem_resp_t resp;
        for (int i = 0; i < WORDS_PER_LINE; i++) begin
            resp.line[32*i +: 32] = (req.addr + 32'(4 * i)) ^ 32'h5a5a_0000;
        end
        resp.load_fault = (req.addr >= 32'h4000_0000) && (req.addr <= 32'h4000_0fff);
        if (resp.load_fault) begin
            resp.line = '0;
        end
        return resp;
    endfunction

    task automatic run_fetch(input logic [87:0] vec);
        exp_addr       = vec[79:48];
        exp_word       = vec[47:16];
        exp_fault      = vec[12];
        exp_refill     = vec[8];
        i_resp_ready   = (vec[7:0] == 0);
        i_req_valid    = 1'b1;
        i_req_addr     = vec[79:48];
        while (!o_req_ready) @(negedge i_clk);
        @(negedge i_clk);
        i_req_valid = (vec[7:0] != 0);   // Kept up while the response is stalled
        while (!o_resp_valid) @(negedge i_clk);
        if (vec[7:0] != 0) begin
            repeat (vec[7:0]) @(negedge i_clk);   // Hold the response back
            i_req_valid  = 1'b0;
            i_resp_ready = 1'b1;
        end
        @(negedge i_clk);
    endtask

    task automatic run_flush(input logic [31:0] addr);
        i_flush_valid = 1'b1;
        i_flush_addr  = addr;
        @(negedge i_clk);
        i_flush_valid = 1'b0;
        while (!o_req_ready) @(negedge i_clk);
        flush_done = 1'b1;
        @(negedge i_clk);
        flush_done = 1'b0;
    endtask

    // Memory model with random grant and response delays
    initial begin : mem_model
        mem_req_t req;
        forever begin
            @(negedge i_clk);
            if (o_mem_valid) begin
                req = o_mem_req;
                repeat (lcg_next() % 4) @(negedge i_clk);
                i_mem_ready = 1'b1;
                @(negedge i_clk);
                i_mem_ready = 1'b0;
                repeat (lcg_next() % 4) @(negedge i_clk);
                i_mem_resp       = make_resp(req);
                i_mem_data_valid = 1'b1;
                @(negedge i_clk);
                i_mem_data_valid = 1'b0;
            end
        end
    end

    always @(posedge i_clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        i_clk            = 1'b0;
        i_nrst           = 1'b0;
        i_req_valid      = 1'b0;
        i_req_addr       = '0;
        i_resp_ready     = 1'b1;
        i_mem_ready      = 1'b0;
        i_mem_data_valid = 1'b0;
        i_mem_resp       = '0;
        i_flush_valid    = 1'b0;
        i_flush_addr     = '0;
        exp_addr         = '0;
        exp_word         = '0;
        exp_fault        = 1'b0;
        exp_refill       = 1'b0;
        test_num         = 0;
        flush_done       = 1'b0;
        report           = 1'b0;
        cycles           = 0;
        lcg_state        = 32'hba0d_921b;
        for (int i = 0; i < MAX_TESTS; i++) begin
            vectors[i] = '0;
        end
        $readmemh("test/icache_tests.txt", vectors);
        num_tests = 0;
        while (num_tests < MAX_TESTS && vectors[num_tests][87:80] != 0) begin
            num_tests++;
        end
        limit = 64 + 200 * num_tests;

        repeat (8) @(negedge i_clk);
        i_nrst = 1'b1;

        for (int t = 0; t < num_tests; t++) begin
            test_num = t + 1;
            case (vectors[t][87:80])
                8'h01:   run_fetch(vectors[t]);
                8'h02:   run_flush(vectors[t][79:48]);
                default: run_flush(vectors[t][79:48] | 32'h1);   // Flush all
            endcase
        end

        report = 1'b1;
        @(negedge i_clk);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
